// File: all.f
+incdir+verilog
verilog/mcore_isa_pkg.sv
verilog/mcore_uop_pkg.sv
verilog/mcore_fetch.sv
verilog/mcore_decode.sv
verilog/mcore_micro_rom.sv
verilog/mcore_exec.sv
verilog/mcore_top.sv
sim/mcore_assertions.sv
sim/mcore_checker.sv
sim/mcore_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = mcore_tb
FLIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// File: sim/mcore_tb.sv
// testbench for the microcoded core
// programs and expected writes are tables, one row per run, reset between rows
// memory models ack 0 to 3 cycles late when a row asks for random delay
// handler code lives at 16'h0040, so rows with an interrupt use iid 4

`include "mcore_macros.svh"

module mcore_tb
  import mcore_isa_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 7;

  logic                 clk;
  logic                 rst;
  logic [`MCORE_AW-1:0] imem_adr;
  logic                 imem_stb;
  logic [`MCORE_DW-1:0] imem_dat = '0;
  logic                 imem_ack = 1'b0;
  logic [`MCORE_AW-1:0] dmem_adr;
  logic [`MCORE_DW-1:0] dmem_wdat;
  logic [`MCORE_DW-1:0] dmem_rdat = '0;
  logic                 dmem_we;
  logic                 dmem_stb;
  logic                 dmem_ack = 1'b0;
  logic                 intr;
  logic [3:0]           iid;
  logic                 inta;

  // program words, handler words, expected {adr, dat} writes
  logic [15:0]       prog [4][16];
  int                prog_len [4];
  logic [15:0]       hnd [3];
  logic [2:0][31:0]  exp_tab [4];
  int                exp_cnt [4];
  int                exp_int [4];
  // rows: program, random delay, interrupt cycle
  int                row_prog [NROWS] = '{0, 1, 2, 0, 1, 2, 3};
  bit                row_rnd [NROWS] = '{0, 0, 0, 1, 1, 1, 0};
  int                row_int [NROWS] = '{0, 0, 0, 0, 0, 0, 30};
  logic [3:0]        row_iid = 4'd4;

  logic [15:0]       imem [128];
  logic [15:0]       dmem [256];
  int                seed = 32'hcd7;
  bit                rnd_delay;
  int                i_wait;
  int                d_wait;
  int                row_cyc;
  int                cycles = 0;
  int                limit = 1 << 30;
  int                cur;
  logic [2:0][31:0]  cur_exp;
  int                cur_cnt;
  int                cur_inta;
  logic              row_done;
  int                wr_seen;
  int                mism_cnt;
  int                miss_cnt;
  int                extra_cnt;
  int                inta_err;
  int                fetch_err;

  mcore_top u_mcore_top (
    .clk        (clk),
    .rst        (rst),
    .imem_adr_o (imem_adr),
    .imem_stb_o (imem_stb),
    .imem_dat_i (imem_dat),
    .imem_ack_i (imem_ack),
    .dmem_adr_o (dmem_adr),
    .dmem_dat_o (dmem_wdat),
    .dmem_we_o  (dmem_we),
    .dmem_stb_o (dmem_stb),
    .dmem_dat_i (dmem_rdat),
    .dmem_ack_i (dmem_ack),
    .intr_i     (intr),
    .iid_i      (iid),
    .inta_o     (inta)
  );

  mcore_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .imem_adr_i (imem_adr),
    .imem_stb_i (imem_stb),
    .imem_ack_i (imem_ack),
    .dmem_adr_i (dmem_adr),
    .dmem_dat_i (dmem_wdat),
    .dmem_we_i  (dmem_we),
    .dmem_stb_i (dmem_stb),
    .dmem_ack_i (dmem_ack),
    .inta_i     (inta),
    .exp_wr_i   (cur_exp),
    .exp_n_i    (cur_cnt),
    .exp_inta_i (cur_inta),
    .exp_vec_i  (16'(row_iid) * 16'd16),
    .row_done_i (row_done),
    .wr_seen_o  (wr_seen),
    .mism_o     (mism_cnt),
    .miss_o     (miss_cnt),
    .extra_o    (extra_cnt),
    .inta_err_o (inta_err),
    .fetch_err_o(fetch_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // register-register and register-immediate encodings
  function automatic logic [15:0] rr_word(opcode_e op, int rd, int rs);
    return {op, 3'(rd), 3'(rs), 6'b0};
  endfunction

  function automatic logic [15:0] ri_word(opcode_e op, int rd, int imm);
    return {op, 3'(rd), 1'b0, 8'(imm)};
  endfunction

  function int pick_delay();
    if (rnd_delay)
      return $random(seed) & 3;
    return 0;
  endfunction

  // one clock, inputs change 2 ns after the edge
  // inta read at the falling edge, settled by then
  task automatic step_cycle();
    logic inta_seen;
    @(negedge clk);
    inta_seen = inta;
    @(posedge clk);
    #2;
    row_cyc++;
    if (inta_seen)
      intr = 1'b0;
    else if (row_int[3'(cur)] != 0 && row_cyc == row_int[3'(cur)])
    begin
      intr = 1'b1;
      iid  = row_iid;
    end
  endtask

  task automatic load_program(int p);
    for (int a = 0; a < 128; a++)
      imem[7'(a)] = '0;
    for (int i = 0; i < prog_len[2'(p)]; i++)
      imem[7'(i)] = prog[2'(p)][4'(i)];
    // handler only for the interrupt program
    if (p == 3)
      for (int i = 0; i < 3; i++)
        imem[7'(64 + i)] = hnd[2'(i)];
  endtask

  // memory models, an ack is taken at the following edge
  always @(posedge clk)
  begin
    #2;
    if (rst)
    begin
      imem_ack = 1'b0;
      dmem_ack = 1'b0;
      i_wait   = -1;
      d_wait   = -1;
      for (int a = 0; a < 256; a++)
        dmem[8'(a)] = {8'(a), ~8'(a)};
    end
    else
    begin
      if (imem_ack)
      begin
        imem_ack = 1'b0;
        i_wait   = -1;
      end
      if (imem_stb)
      begin
        if (i_wait < 0)
          i_wait = pick_delay();
        if (i_wait == 0)
        begin
          imem_ack = 1'b1;
          imem_dat = imem[imem_adr[6:0]];
        end
        else
          i_wait--;
      end
      if (dmem_ack)
      begin
        dmem_ack = 1'b0;
        d_wait   = -1;
      end
      if (dmem_stb)
      begin
        if (d_wait < 0)
          d_wait = pick_delay();
        if (d_wait == 0)
        begin
          dmem_ack = 1'b1;
          if (dmem_we)
            dmem[dmem_adr[7:0]] = dmem_wdat;
          else
            dmem_rdat = dmem[dmem_adr[7:0]];
        end
        else
          d_wait--;
      end
    end
  end

  // run limit from the total program length
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("timeout: no finish after %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    int total;
    logic [15:0] v;
    rst      = 1'b1;
    intr     = 1'b0;
    iid      = 4'h0;
    row_done = 1'b0;
    cur      = 0;
    cur_exp  = '0;
    cur_cnt  = 0;
    cur_inta = 0;
    rnd_delay = 1'b0;
    // arithmetic, two stores of 16-bit results
    prog[0][0] = ri_word(OP_LDI, 1, 8'h35);
    prog[0][1] = ri_word(OP_LDI, 2, 8'h0f);
    prog[0][2] = rr_word(OP_ADD, 1, 2);
    prog[0][3] = rr_word(OP_XOR, 1, 2);
    prog[0][4] = rr_word(OP_SUB, 1, 2);
    prog[0][5] = ri_word(OP_LDI, 4, 8'h80);
    prog[0][6] = rr_word(OP_ST, 1, 4);
    prog[0][7] = ri_word(OP_LDI, 3, 8'h01);
    prog[0][8] = rr_word(OP_SUB, 3, 2);
    prog[0][9] = rr_word(OP_ST, 3, 4);
    prog_len[0] = 10;
    v = ((16'h0035 + 16'h000f) ^ 16'h000f) - 16'h000f;
    exp_tab[0][0] = {16'h0080, v};
    v = 16'h0001 - 16'h000f;
    exp_tab[0][1] = {16'h0080, v};
    exp_tab[0][2] = '0;
    exp_cnt[0] = 2;
    // store, load back, store the loaded register elsewhere
    prog[1][0] = ri_word(OP_LDI, 1, 8'h77);
    prog[1][1] = ri_word(OP_LDI, 2, 8'h20);
    prog[1][2] = rr_word(OP_ST, 1, 2);
    prog[1][3] = rr_word(OP_LD, 3, 2);
    prog[1][4] = ri_word(OP_LDI, 4, 8'h21);
    prog[1][5] = rr_word(OP_ST, 3, 4);
    prog_len[1] = 6;
    exp_tab[1][0] = {16'h0020, 16'h0077};
    exp_tab[1][1] = {16'h0021, 16'h0077};
    exp_tab[1][2] = '0;
    exp_cnt[1] = 2;
    // taken jz skips the store of 5, untaken jz lets the store of 2 through
    prog[2][0] = ri_word(OP_LDI, 1, 8'h05);
    prog[2][1] = ri_word(OP_LDI, 2, 8'h05);
    prog[2][2] = ri_word(OP_LDI, 3, 8'h40);
    prog[2][3] = rr_word(OP_SUB, 1, 2);
    prog[2][4] = ri_word(OP_JZ, 0, 8'h01);
    prog[2][5] = rr_word(OP_ST, 2, 3);
    prog[2][6] = ri_word(OP_LDI, 1, 8'h07);
    prog[2][7] = rr_word(OP_SUB, 1, 2);
    prog[2][8] = ri_word(OP_JZ, 0, 8'h01);
    prog[2][9] = rr_word(OP_ST, 1, 3);
    prog_len[2] = 10;
    exp_tab[2] = '0;
    exp_tab[2][0] = {16'h0040, 16'h0002};
    exp_cnt[2] = 1;
    // store, then spin on jz at 4 until the interrupt
    prog[3][0] = ri_word(OP_LDI, 1, 8'h33);
    prog[3][1] = ri_word(OP_LDI, 7, 8'h80);
    prog[3][2] = rr_word(OP_ST, 1, 7);
    prog[3][3] = rr_word(OP_SUB, 2, 2);
    prog[3][4] = ri_word(OP_JZ, 0, 8'hff);
    prog_len[3] = 5;
    hnd[0] = ri_word(OP_LDI, 5, 8'h5a);
    hnd[1] = ri_word(OP_LDI, 6, 8'h90);
    hnd[2] = rr_word(OP_ST, 5, 6);
    exp_tab[3][0] = {16'h0080, 16'h0033};
    exp_tab[3][1] = {`MCORE_SAVE_ADR, 16'h0004};
    exp_tab[3][2] = {16'h0090, 16'h005a};
    exp_cnt[3] = 3;
    exp_int = '{0, 0, 0, 1};
    total = 0;
    for (int r = 0; r < NROWS; r++)
      total += prog_len[2'(row_prog[3'(r)])] + (row_prog[3'(r)] == 3 ? 3 : 0);
    limit = total * 40;

    for (int r = 0; r < NROWS; r++)
    begin
      rst       = 1'b1;
      cur       = r;
      rnd_delay = row_rnd[3'(r)];
      cur_exp   = exp_tab[2'(row_prog[3'(r)])];
      cur_cnt   = exp_cnt[2'(row_prog[3'(r)])];
      cur_inta  = exp_int[2'(row_prog[3'(r)])];
      load_program(row_prog[3'(r)]);
      repeat (5) @(posedge clk);
      #2;
      rst     = 1'b0;
      row_cyc = 0;
      while (wr_seen < cur_cnt)
        step_cycle();
      // room for any extra write to show up
      repeat (20) step_cycle();
      row_done = 1'b1;
      step_cycle();
      row_done = 1'b0;
    end

    $display("errors: mismatch %0d missing %0d extra %0d inta %0d fetch %0d",
             mism_cnt, miss_cnt, extra_cnt, inta_err, fetch_err);
    if (mism_cnt + miss_cnt + extra_cnt + inta_err + fetch_err == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: sim/mcore_checker.sv
// watches the core ports and compares against the expected row
// writes are matched in order, a write past the list counts as extra
// per-row state clears in reset, the error counts never do

`include "mcore_macros.svh"

module mcore_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic [15:0]      imem_adr_i,
  input  logic             imem_stb_i,
  input  logic             imem_ack_i,
  input  logic [15:0]      dmem_adr_i,
  input  logic [15:0]      dmem_dat_i,
  input  logic             dmem_we_i,
  input  logic             dmem_stb_i,
  input  logic             dmem_ack_i,
  input  logic             inta_i,
  input  logic [2:0][31:0] exp_wr_i,
  input  int               exp_n_i,
  input  int               exp_inta_i,
  input  logic [15:0]      exp_vec_i,
  input  logic             row_done_i,
  output int               wr_seen_o,
  output int               mism_o,
  output int               miss_o,
  output int               extra_o,
  output int               inta_err_o,
  output int               fetch_err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int         wr_idx = 0;
  int         inta_cnt = 0;
  int         mism_cnt = 0;
  int         miss_cnt = 0;
  int         extra_cnt = 0;
  int         inta_bad = 0;
  int         fetch_bad = 0;
  logic       stb_q;
  logic       ack_q;
  logic       want_first;
  logic       want_vec;
  logic       new_req;
  logic [1:0] sel;

  // request starts: strobe rises, or stays up right after an ack
  assign new_req = imem_stb_i & (~stb_q | ack_q);
  assign sel     = wr_idx[1:0];

  always @(posedge clk)
  begin
    if (rst)
    begin
      wr_idx     <= 0;
      inta_cnt   <= 0;
      stb_q      <= 1'b0;
      ack_q      <= 1'b0;
      want_first <= 1'b1;
      want_vec   <= 1'b0;
    end
    else
    begin
      stb_q <= imem_stb_i;
      ack_q <= imem_ack_i;
      // accepted write
      if (dmem_stb_i & dmem_we_i & dmem_ack_i)
      begin
        if (wr_idx >= exp_n_i)
        begin
          extra_cnt <= extra_cnt + 1;
          $display("[ERROR] %0t: extra write %h to %h", $time, dmem_dat_i, dmem_adr_i);
        end
        else if ({dmem_adr_i, dmem_dat_i} !== exp_wr_i[sel])
        begin
          mism_cnt <= mism_cnt + 1;
          $display("[ERROR] %0t: write %0d is %h:%h, expected %h:%h", $time, wr_idx,
                   dmem_adr_i, dmem_dat_i, exp_wr_i[sel][31:16], exp_wr_i[sel][15:0]);
        end
        wr_idx <= wr_idx + 1;
      end
      if (inta_i)
        inta_cnt <= inta_cnt + 1;
      // first fetch after reset
      if (new_req & want_first)
      begin
        want_first <= 1'b0;
        if (imem_adr_i !== `MCORE_RESET_IP)
        begin
          fetch_bad <= fetch_bad + 1;
          $display("[ERROR] %0t: first fetch at %h", $time, imem_adr_i);
        end
      end
      // first new request after inta goes to the vector
      if (new_req & want_vec)
      begin
        want_vec <= 1'b0;
        if (imem_adr_i !== exp_vec_i)
        begin
          inta_bad <= inta_bad + 1;
          $display("[ERROR] %0t: vector fetch at %h, expected %h", $time, imem_adr_i,
                   exp_vec_i);
        end
      end
      if (inta_i)
        want_vec <= 1'b1;
      if (row_done_i)
      begin
        if (wr_idx < exp_n_i)
        begin
          miss_cnt <= miss_cnt + exp_n_i - wr_idx;
          $display("missing writes: saw %0d of %0d", wr_idx, exp_n_i);
        end
        if (inta_cnt != exp_inta_i)
        begin
          inta_bad <= inta_bad + 1;
          $display("[ERROR] %0t: inta was high %0d cycles, expected %0d", $time,
                   inta_cnt, exp_inta_i);
        end
        if (want_vec)
        begin
          inta_bad <= inta_bad + 1;
          $display("no fetch from the vector after inta");
        end
      end
    end
  end

  assign wr_seen_o   = wr_idx;
  assign mism_o      = mism_cnt;
  assign miss_o      = miss_cnt;
  assign extra_o     = extra_cnt;
  assign inta_err_o  = inta_bad;
  assign fetch_err_o = fetch_bad;

endmodule

// File: sim/mcore_assertions.sv
// port protocol properties, bound into the core top
// strobes hold with stable outputs until ack, inta is one cycle

module mcore_assertions (
  input logic        clk,
  input logic        rst,
  input logic [15:0] imem_adr_o,
  input logic        imem_stb_o,
  input logic        imem_ack_i,
  input logic [15:0] dmem_adr_o,
  input logic [15:0] dmem_dat_o,
  input logic        dmem_we_o,
  input logic        dmem_stb_o,
  input logic        dmem_ack_i,
  input logic        inta_o
);
  timeunit 1ns;
  timeprecision 1ps;

  imem_hold: assert property (@(posedge clk) disable iff (rst)
    imem_stb_o && !imem_ack_i |=> imem_stb_o && $stable(imem_adr_o))
    else $error("instruction strobe dropped or address moved before ack");

  dmem_hold: assert property (@(posedge clk) disable iff (rst)
    dmem_stb_o && !dmem_ack_i |=> dmem_stb_o && $stable(dmem_adr_o)
      && $stable(dmem_dat_o) && $stable(dmem_we_o))
    else $error("data strobe dropped or outputs moved before ack");

  inta_pulse: assert property (@(posedge clk) disable iff (rst)
    inta_o |=> !inta_o)
    else $error("inta longer than one cycle");

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk)
    $past(rst) && !rst |-> !imem_stb_o && !dmem_stb_o && !dmem_we_o && !inta_o)
    else $error("strobes not low after reset");

endmodule

bind mcore_top mcore_assertions u_mcore_assertions (.*);

// File: verilog/mcore_top.sv
// core top: fetch, decode, micro rom and exec
// holds the registered microinstruction between rom and exec
// the whole pipeline freezes while a data access waits for ack
// intr_i is a level, iid_i is read in the cycle the interrupt is taken

`include "mcore_macros.svh"

module mcore_top
  import mcore_isa_pkg::*, mcore_uop_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  // instruction port
  output logic [`MCORE_AW-1:0] imem_adr_o,
  output logic                 imem_stb_o,
  input  logic [`MCORE_DW-1:0] imem_dat_i,
  input  logic                 imem_ack_i,
  // data port
  output logic [`MCORE_AW-1:0] dmem_adr_o,
  output logic [`MCORE_DW-1:0] dmem_dat_o,
  output logic                 dmem_we_o,
  output logic                 dmem_stb_o,
  input  logic [`MCORE_DW-1:0] dmem_dat_i,
  input  logic                 dmem_ack_i,
  // interrupt
  input  logic                 intr_i,
  input  logic [3:0]           iid_i,
  output logic                 inta_o
);

  instr_u               instr;
  logic                 instr_valid;
  logic [`MCORE_AW-1:0] next_ip;
  logic                 take;
  logic                 redirect;
  logic [`MCORE_AW-1:0] redirect_ip;
  useq_t                seq;
  logic                 issue;
  uop_t                 rom_uop;
  uop_t                 ex_uop;
  useq_t                ex_seq;
  exec_stat_t           stat;
  logic                 stall;

  mcore_fetch u_fetch (
    .clk           (clk),
    .rst           (rst),
    .imem_adr_o    (imem_adr_o),
    .imem_stb_o    (imem_stb_o),
    .imem_dat_i    (imem_dat_i),
    .imem_ack_i    (imem_ack_i),
    .take_i        (take),
    .redirect_i    (redirect),
    .redirect_ip_i (redirect_ip),
    .instr_o       (instr),
    .instr_valid_o (instr_valid),
    .next_ip_o     (next_ip)
  );

  mcore_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .next_ip_i     (next_ip),
    .stall_i       (stall),
    .exec_stat_i   (stat),
    // end bit of the step being issued
    .end_seq_i     (rom_uop.last),
    .intr_i        (intr_i),
    .iid_i         (iid_i),
    .take_o        (take),
    .seq_o         (seq),
    .issue_o       (issue),
    .inta_o        (inta_o),
    .redirect_o    (redirect),
    .redirect_ip_o (redirect_ip)
  );

  mcore_micro_rom u_micro_rom (
    .seq_i (seq),
    .uop_o (rom_uop)
  );

  mcore_exec u_exec (
    .clk        (clk),
    .rst        (rst),
    .uop_i      (ex_uop),
    .seq_i      (ex_seq),
    .dmem_adr_o (dmem_adr_o),
    .dmem_dat_o (dmem_dat_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_stb_o (dmem_stb_o),
    .dmem_dat_i (dmem_dat_i),
    .dmem_ack_i (dmem_ack_i),
    .stat_o     (stat)
  );

  // data access still waiting
  assign stall = dmem_stb_o & ~dmem_ack_i;

  // registered microinstruction, a nop bubble when nothing issues
  always_ff @(posedge clk)
  begin
    if (rst)
      ex_uop <= '0;
    else if (~stall)
      ex_uop <= issue ? rom_uop : '0;
  end

  // operands travel alongside
  always_ff @(posedge clk)
  begin
    if (~stall)
      ex_seq <= seq;
  end

endmodule

// File: verilog/mcore_exec.sv
// execute stage: register file, alu, zero flag and data port
// a memory uop drives the port straight from the pipeline register,
// so strobe and address hold while top stalls on a missing ack
// only add, sub and xor touch the zero flag

`include "mcore_macros.svh"

module mcore_exec
  import mcore_uop_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  uop_t                 uop_i,
  input  useq_t                seq_i,
  output logic [`MCORE_AW-1:0] dmem_adr_o,
  output logic [`MCORE_DW-1:0] dmem_dat_o,
  output logic                 dmem_we_o,
  output logic                 dmem_stb_o,
  input  logic [`MCORE_DW-1:0] dmem_dat_i,
  input  logic                 dmem_ack_i,
  output exec_stat_t           stat_o
);

  logic [`MCORE_DW-1:0] regs [8];
  logic [`MCORE_DW-1:0] mdr;
  logic [`MCORE_DW-1:0] op_a;
  logic [`MCORE_DW-1:0] op_b;
  logic [`MCORE_DW-1:0] alu_res;
  logic                 zf;

  // a is always rd, b per the uop
  assign op_a = regs[seq_i.rd];

  always_comb
  begin
    case (uop_i.bsrc)
      BSRC_IMM: op_b = seq_i.imm;
      BSRC_MDR: op_b = mdr;
      default:  op_b = regs[seq_i.rs];
    endcase
  end

  always_comb
  begin
    case (uop_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      // ip carried in the immediate
      ALU_PASSIP: alu_res = seq_i.imm;
      default:    alu_res = op_b;
    endcase
  end

  // register writes never come from a memory step
  always_ff @(posedge clk)
  begin
    if (uop_i.reg_wr)
      regs[seq_i.rd] <= alu_res;
    // load data captured on ack
    if (uop_i.mem_rd & dmem_ack_i)
      mdr <= dmem_dat_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      zf <= 1'b0;
    else if (uop_i.flag_wr)
      zf <= (alu_res == '0);
  end

  // data port
  assign dmem_stb_o = uop_i.mem_rd | uop_i.mem_wr;
  assign dmem_we_o  = uop_i.mem_wr;
  assign dmem_adr_o = uop_i.use_save ? `MCORE_SAVE_ADR : regs[seq_i.rs];
  // st writes rd, the interrupt store writes the return ip
  assign dmem_dat_o = uop_i.use_save ? alu_res : op_a;

  // branch resolution, target from the alu pass
  assign stat_o.taken  = uop_i.br_z & zf;
  assign stat_o.target = alu_res;
  assign stat_o.zf     = zf;

endmodule

// File: verilog/mcore_micro_rom.sv
// combinational microcode table
// addresses without an entry read as a single nop step
// only the sequence address of seq_i selects the entry

module mcore_micro_rom
  import mcore_uop_pkg::*;
(
  input  useq_t seq_i,
  output uop_t  uop_o
);

  always_comb
  begin
    uop_o = '0;
    case (seq_i.uaddr)
      UA_LDI:
      begin
        uop_o.bsrc   = BSRC_IMM;
        uop_o.reg_wr = 1'b1;
      end
      UA_ADD, UA_SUB, UA_XOR:
      begin
        // alu op follows the entry
        if (seq_i.uaddr == UA_ADD)
          uop_o.alu_op = ALU_ADD;
        else if (seq_i.uaddr == UA_SUB)
          uop_o.alu_op = ALU_SUB;
        else
          uop_o.alu_op = ALU_XOR;
        uop_o.reg_wr  = 1'b1;
        uop_o.flag_wr = 1'b1;
      end
      // load: read into mdr, then write back
      UA_LD0: uop_o.mem_rd = 1'b1;
      UA_LD1:
      begin
        uop_o.bsrc   = BSRC_MDR;
        uop_o.reg_wr = 1'b1;
      end
      UA_ST:  uop_o.mem_wr = 1'b1;
      UA_JZ:
      begin
        uop_o.alu_op = ALU_PASSIP;
        uop_o.br_z   = 1'b1;
      end
      // interrupt: store return ip, then an empty closing step
      UA_INT0:
      begin
        uop_o.alu_op   = ALU_PASSIP;
        uop_o.mem_wr   = 1'b1;
        uop_o.use_save = 1'b1;
      end
      default: uop_o = '0;
    endcase
    // every entry ends its sequence except the first of a pair
    uop_o.last = (seq_i.uaddr != UA_LD0) && (seq_i.uaddr != UA_INT0);
  end

endmodule

// File: verilog/mcore_decode.sv
// decode and microcode sequencer
// issues one step per unstalled cycle, steps on until the rom end bit
// jz waits for an empty exec stage and blocks issue for one cycle
// after it, while exec resolves the branch
// interrupts are taken only with an instruction in the buffer

`include "mcore_macros.svh"

module mcore_decode
  import mcore_isa_pkg::*, mcore_uop_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  instr_u               instr_i,
  input  logic                 instr_valid_i,
  input  logic [`MCORE_AW-1:0] next_ip_i,
  input  logic                 stall_i,
  input  exec_stat_t           exec_stat_i,
  input  logic                 end_seq_i,
  input  logic                 intr_i,
  input  logic [3:0]           iid_i,
  output logic                 take_o,
  output useq_t                seq_o,
  output logic                 issue_o,
  output logic                 inta_o,
  output logic                 redirect_o,
  output logic [`MCORE_AW-1:0] redirect_ip_o
);

  useq_t dec_seq;
  useq_t int_seq;
  useq_t cur_seq;
  logic  in_seq;
  logic  br_pend;
  logic  ex_busy;
  logic  is_jz;
  logic  boundary;
  logic  take_int;
  logic  take_ins;
  logic  fire;

  // opcode to sequence start, operands straight from the word
  always_comb
  begin
    dec_seq.rd  = instr_i.rr.rd;
    dec_seq.rs  = instr_i.rr.rs;
    dec_seq.imm = {8'h00, instr_i.ri.imm};
    case (instr_i.rr.op)
      OP_LDI: dec_seq.uaddr = UA_LDI;
      OP_ADD: dec_seq.uaddr = UA_ADD;
      OP_SUB: dec_seq.uaddr = UA_SUB;
      OP_XOR: dec_seq.uaddr = UA_XOR;
      OP_LD:  dec_seq.uaddr = UA_LD0;
      OP_ST:  dec_seq.uaddr = UA_ST;
      OP_JZ:
      begin
        dec_seq.uaddr = UA_JZ;
        // target computed here, exec only checks the flag
        dec_seq.imm   = next_ip_i + {{8{instr_i.ri.imm[7]}}, instr_i.ri.imm};
      end
      default: dec_seq.uaddr = UA_NOP;
    endcase
  end

  // return ip is the address of the buffered instruction
  always_comb
  begin
    int_seq.uaddr = UA_INT0;
    int_seq.rd    = '0;
    int_seq.rs    = '0;
    int_seq.imm   = next_ip_i - 1'b1;
  end

  assign is_jz    = (instr_i.rr.op == OP_JZ);
  assign boundary = ~in_seq & ~br_pend & instr_valid_i;
  assign take_int = boundary & intr_i;
  // jz only once earlier uops have left exec
  assign take_ins = boundary & ~intr_i & ~(is_jz & ex_busy);

  assign issue_o = in_seq | take_int | take_ins;
  assign fire    = issue_o & ~stall_i;

  always_comb
  begin
    if (in_seq)
      seq_o = cur_seq;
    else if (take_int)
      seq_o = int_seq;
    else
      seq_o = dec_seq;
  end

  // interrupt leaves the buffered word, the redirect drops it
  assign take_o = take_ins & ~stall_i;
  assign inta_o = take_int & ~stall_i;

  // single redirect: branch from exec or interrupt vector
  assign redirect_o    = exec_stat_i.taken | inta_o;
  assign redirect_ip_o = exec_stat_i.taken ? exec_stat_i.target
                                           : {{(`MCORE_AW-8){1'b0}}, iid_i, 4'h0};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      in_seq  <= 1'b0;
      br_pend <= 1'b0;
      ex_busy <= 1'b0;
    end
    else if (~stall_i)
    begin
      in_seq  <= issue_o & ~end_seq_i;
      br_pend <= take_ins & is_jz;
      ex_busy <= issue_o;
    end
  end

  // next step of the running sequence
  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      cur_seq       <= seq_o;
      cur_seq.uaddr <= uaddr_e'(seq_o.uaddr + 1'b1);
    end
  end

endmodule

// File: verilog/mcore_fetch.sv
// instruction fetch with a one-word buffer
// at most one fetch is outstanding, and it is only started when the
// buffer is empty or being taken, so an ack always finds room
// a redirect during a fetch waits for its ack and drops the word

`include "mcore_macros.svh"

module mcore_fetch
  import mcore_isa_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  output logic [`MCORE_AW-1:0] imem_adr_o,
  output logic                 imem_stb_o,
  input  logic [`MCORE_DW-1:0] imem_dat_i,
  input  logic                 imem_ack_i,
  input  logic                 take_i,
  input  logic                 redirect_i,
  input  logic [`MCORE_AW-1:0] redirect_ip_i,
  output instr_u               instr_o,
  output logic                 instr_valid_o,
  output logic [`MCORE_AW-1:0] next_ip_o
);

  logic [`MCORE_AW-1:0] ip;
  logic [`MCORE_AW-1:0] ip_n;
  logic [`MCORE_AW-1:0] buf_ip;
  instr_u               ibuf;
  logic                 buf_valid;
  logic                 buf_valid_n;
  logic                 drop;
  logic                 acc;
  logic                 keep;
  logic                 hold;
  logic                 stb_n;
  logic                 start;

  // fetch completes this cycle
  assign acc  = imem_stb_o & imem_ack_i;
  // word is wanted: not flushed before or during this cycle
  assign keep = acc & ~drop & ~redirect_i;
  // strobe must stay up until ack
  assign hold = imem_stb_o & ~imem_ack_i;

  always_comb
  begin
    buf_valid_n = buf_valid;
    if (take_i | redirect_i)
      buf_valid_n = 1'b0;
    if (keep)
      buf_valid_n = 1'b1;
  end

  // request again as soon as the buffer will be empty
  assign stb_n = hold | ~buf_valid_n;
  assign start = stb_n & ~hold;
  assign ip_n  = redirect_i ? redirect_ip_i : (keep ? imem_adr_o + 1'b1 : ip);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ip         <= `MCORE_RESET_IP;
      imem_stb_o <= 1'b0;
      buf_valid  <= 1'b0;
      drop       <= 1'b0;
    end
    else
    begin
      ip         <= ip_n;
      imem_stb_o <= stb_n;
      buf_valid  <= buf_valid_n;
      // stale fetch in flight, ignore its word
      if (acc)
        drop <= 1'b0;
      else if (redirect_i & imem_stb_o)
        drop <= 1'b1;
    end
  end

  // address latched at request start, stable while strobe holds
  always_ff @(posedge clk)
  begin
    if (start)
      imem_adr_o <= ip_n;
    if (keep)
    begin
      ibuf   <= imem_dat_i;
      buf_ip <= imem_adr_o;
    end
  end

  assign instr_o       = ibuf;
  assign instr_valid_o = buf_valid;
  assign next_ip_o     = buf_ip + 1'b1;

endmodule

// File: verilog/mcore_uop_pkg.sv
// microcode level types shared by decode, micro rom and exec
// sequence start addresses live here as an enum, so decode
// and the rom table agree on them

`include "mcore_macros.svh"

package mcore_uop_pkg;
  import mcore_isa_pkg::*;

  // microcode entries, multi-step sequences are consecutive
  typedef enum logic [`MCORE_UADDR_W-1:0] {
    UA_NOP  = 4'd0,
    UA_LDI  = 4'd1,
    UA_ADD  = 4'd2,
    UA_SUB  = 4'd3,
    UA_XOR  = 4'd4,
    UA_LD0  = 4'd5,
    UA_LD1  = 4'd6,
    UA_ST   = 4'd7,
    UA_JZ   = 4'd8,
    UA_INT0 = 4'd9,
    UA_INT1 = 4'd10
  } uaddr_e;

  // pass-ip forwards the immediate, which carries an ip
  typedef enum logic [2:0] {
    ALU_PASSB,
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_PASSIP
  } alu_op_e;

  // b operand: register rs, immediate, or the load data register
  typedef enum logic [1:0] {
    BSRC_REG,
    BSRC_IMM,
    BSRC_MDR
  } bsrc_e;

  // one microinstruction, all zero is a nop step
  typedef struct packed {
    alu_op_e alu_op;
    bsrc_e   bsrc;
    logic    mem_rd;
    logic    mem_wr;
    logic    reg_wr;
    logic    flag_wr;
    logic    br_z;
    logic    use_save;
    logic    last;
  } uop_t;

  // decoder output, addresses the rom and feeds exec operands
  typedef struct packed {
    uaddr_e                 uaddr;
    reg_idx_t               rd;
    reg_idx_t               rs;
    logic [`MCORE_DW-1:0]   imm;
  } useq_t;

  // branch outcome back to decode and fetch
  typedef struct packed {
    logic                 taken;
    logic [`MCORE_AW-1:0] target;
    logic                 zf;
  } exec_stat_t;

endpackage

// File: verilog/mcore_isa_pkg.sv
// instruction set encoding, one 16-bit word per instruction
// opcode sits in the top nibble in both views of the word
// unknown opcodes are executed as nop by the decoder

package mcore_isa_pkg;

  // top nibble of every instruction
  typedef enum logic [3:0] {
    OP_NOP = 4'h0,
    OP_LDI = 4'h1,
    OP_ADD = 4'h2,
    OP_SUB = 4'h3,
    OP_XOR = 4'h4,
    OP_LD  = 4'h5,
    OP_ST  = 4'h6,
    OP_JZ  = 4'h7
  } opcode_e;

  // eight general registers
  typedef logic [2:0] reg_idx_t;

  // register-register form: add/sub/xor/ld/st
  typedef struct packed {
    opcode_e    op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    logic [5:0] unused;
  } instr_rr_t;

  // register-immediate form: ldi, and jz with rd ignored
  typedef struct packed {
    opcode_e    op;
    reg_idx_t   rd;
    logic       unused;
    logic [7:0] imm;
  } instr_ri_t;

  // same word, read either way by the decoder
  typedef union packed {
    instr_rr_t rr;
    instr_ri_t ri;
  } instr_u;

endpackage

// File: verilog/mcore_macros.svh
// shared widths and fixed addresses for the core
// address and data widths must stay equal, since the ip travels
// through the 16-bit immediate path and the data port
// the save address must not overlap program or data memory

`ifndef MCORE_MACROS_SVH
`define MCORE_MACROS_SVH

// port widths
`define MCORE_AW 16
`define MCORE_DW 16

// first fetch address after reset
`define MCORE_RESET_IP 16'h0000

// where the interrupt return ip is written
`define MCORE_SAVE_ADR 16'hfff0

// microcode address width, 16 entries at most
`define MCORE_UADDR_W 4

`endif
